//--- hdl/branch_pkg.sv
package branch_pkg;

    // Core sizing
    localparam int unsigned num_tags      = 4;
    localparam int unsigned arch_regs     = 8;
    localparam int unsigned phys_regs     = 16;
    localparam int unsigned rob_entries   = 16;
    localparam int unsigned repair_cycles = 3;

    // Derived index widths
    localparam int unsigned tag_bits   = $clog2(num_tags);
    localparam int unsigned phys_bits  = $clog2(phys_regs);
    localparam int unsigned rob_bits   = $clog2(rob_entries);
    localparam int unsigned timer_bits = $clog2(repair_cycles + 1);

    typedef logic [31:0]               addr_t;
    typedef logic [num_tags-1:0]       b_mask_t;
    typedef logic [tag_bits-1:0]       tag_t;
    typedef logic [phys_bits-1:0]      phys_idx_t;
    typedef logic [rob_bits-1:0]       rob_idx_t;
    typedef phys_idx_t [arch_regs-1:0] map_table_t;
    typedef logic [phys_regs-1:0]      free_list_t;
    typedef logic [timer_bits-1:0]     timer_count_t;

    typedef enum logic {
        state_idle,
        state_repair
    } recovery_state_t;

    // Snapshot sent by dispatch for every branch or jump
    typedef struct packed {
        addr_t      branch_pc;
        addr_t      fallthrough_pc;
        addr_t      predicted_target;
        logic       is_jump;
        rob_idx_t   rob_tail;
        map_table_t map_table;
        free_list_t free_list;
    } ckpt_req_t;

    // Stored entry, depend_mask holds the older unresolved tags
    typedef struct packed {
        logic       valid;
        b_mask_t    depend_mask;
        ckpt_req_t  req;
    } checkpoint_t;

    typedef struct packed {
        tag_t       tag;
        logic       mispredict;
        logic       taken;
        addr_t      target_pc;
    } resolve_t;

    typedef struct packed {
        logic       valid;
        addr_t      pc;
        rob_idx_t   rob_tail;
        map_table_t map_table;
        free_list_t free_list;
    } restore_t;

    typedef struct packed {
        logic       valid;
        logic       is_branch;
        logic       taken;
        addr_t      branch_pc;
        addr_t      target_pc;
    } btb_update_t;

endpackage

//--- hdl/checkpoint_stack.sv
`timescale 1ns/1ps

module checkpoint_stack (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    ckpt_valid,
    input  branch_pkg::ckpt_req_t   ckpt_req,
    output logic                    ckpt_ready,
    output branch_pkg::tag_t        alloc_tag,
    output branch_pkg::b_mask_t     branch_mask,
    input  logic                    resolve_valid,
    input  branch_pkg::resolve_t    resolve,
    output logic                    resolve_ready,
    input  branch_pkg::free_list_t  free_list_in,
    input  logic                    recovering,
    output branch_pkg::restore_t    restore_candidate,
    output branch_pkg::btb_update_t btb_update
);

    branch_pkg::checkpoint_t ckpt_q [branch_pkg::num_tags];
    branch_pkg::checkpoint_t ckpt_d [branch_pkg::num_tags];
    branch_pkg::checkpoint_t resolved_ckpt;
    branch_pkg::b_mask_t     resolve_onehot;
    branch_pkg::b_mask_t     squash_mask;
    branch_pkg::b_mask_t     clear_mask;
    branch_pkg::b_mask_t     surviving_mask;

    logic ckpt_fire;
    logic resolve_fire;
    logic resolve_hit;
    logic jump_mismatch;
    logic mispredict;
    logic tag_free;

    // Live tags are simply the valid bits of the entries
    always_comb begin
        for (int i = 0; i < branch_pkg::num_tags; i++) begin
            branch_mask[i] = ckpt_q[i].valid;
        end
    end

    // Lowest free tag wins, scan from the top so the last hit is the lowest
    always_comb begin
        alloc_tag = '0;
        tag_free  = 1'b0;
        for (int i = branch_pkg::num_tags - 1; i >= 0; i--) begin
            if (!branch_mask[i]) begin
                alloc_tag = branch_pkg::tag_t'(i);
                tag_free  = 1'b1;
            end
        end
    end

    assign ckpt_ready    = tag_free && !recovering;
    assign resolve_ready = !recovering;
    assign ckpt_fire     = ckpt_valid && ckpt_ready;
    assign resolve_fire  = resolve_valid && resolve_ready;

    // Resolves for dead tags are taken but have no effect
    assign resolved_ckpt = ckpt_q[resolve.tag];
    assign resolve_hit   = resolve_fire && branch_mask[resolve.tag];

    // Jumps are judged on the target alone, branches on the reported outcome
    assign jump_mismatch = resolved_ckpt.req.is_jump &&
                           (resolve.target_pc != resolved_ckpt.req.predicted_target);
    assign mispredict    = resolve_hit &&
                           (resolved_ckpt.req.is_jump ? jump_mismatch : resolve.mispredict);

    // Squash covers the tag itself and every checkpoint that depends on it
    always_comb begin
        resolve_onehot = '0;
        squash_mask    = '0;
        clear_mask     = '0;
        if (resolve_hit) begin
            resolve_onehot[resolve.tag] = 1'b1;
            if (mispredict) begin
                squash_mask = resolve_onehot;
                for (int i = 0; i < branch_pkg::num_tags; i++) begin
                    if (ckpt_q[i].valid && ckpt_q[i].depend_mask[resolve.tag]) begin
                        squash_mask[i] = 1'b1;
                    end
                end
            end else begin
                clear_mask = resolve_onehot;
            end
        end
    end

    // Mask a new checkpoint sees once this cycle's resolve has acted
    assign surviving_mask = branch_mask & ~squash_mask & ~clear_mask;

    always_comb begin
        for (int i = 0; i < branch_pkg::num_tags; i++) begin
            ckpt_d[i] = ckpt_q[i];
            if (squash_mask[i] || clear_mask[i]) begin
                ckpt_d[i].valid       = 1'b0;
                ckpt_d[i].depend_mask = '0;
            end else if (ckpt_q[i].valid) begin
                ckpt_d[i].depend_mask   = ckpt_q[i].depend_mask & ~clear_mask;
                // Registers retired since the snapshot are free after a restore too
                ckpt_d[i].req.free_list = ckpt_q[i].req.free_list | free_list_in;
            end

            // A checkpoint dispatched alongside a mispredict is on the wrong path,
            // so the handshake completes but nothing is stored
            if (ckpt_fire && !mispredict && (alloc_tag == branch_pkg::tag_t'(i))) begin
                ckpt_d[i].valid       = 1'b1;
                ckpt_d[i].depend_mask = surviving_mask;
                ckpt_d[i].req         = ckpt_req;
            end
        end
    end

    // Restore candidate, the FSM registers it
    always_comb begin
        restore_candidate.valid     = mispredict;
        restore_candidate.pc        = resolved_ckpt.req.fallthrough_pc;
        restore_candidate.rob_tail  = resolved_ckpt.req.rob_tail;
        restore_candidate.map_table = resolved_ckpt.req.map_table;
        restore_candidate.free_list = resolved_ckpt.req.free_list | free_list_in;
        if (resolved_ckpt.req.is_jump || resolve.taken) begin
            restore_candidate.pc = resolve.target_pc;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < branch_pkg::num_tags; i++) begin
                ckpt_q[i].valid       <= 1'b0;
                ckpt_q[i].depend_mask <= '0;
            end
        end else begin
            for (int i = 0; i < branch_pkg::num_tags; i++) begin
                ckpt_q[i] <= ckpt_d[i];
            end
        end
    end

    // Predictor update one cycle after every live resolve
    always_ff @(posedge clock) begin
        if (reset) begin
            btb_update.valid <= 1'b0;
        end else begin
            btb_update.valid <= resolve_hit;
            if (resolve_hit) begin
                btb_update.is_branch <= !resolved_ckpt.req.is_jump;
                btb_update.taken     <= resolved_ckpt.req.is_jump || resolve.taken;
                btb_update.branch_pc <= resolved_ckpt.req.branch_pc;
                btb_update.target_pc <= resolve.target_pc;
            end
        end
    end

endmodule

//--- hdl/recovery_fsm.sv
`timescale 1ns/1ps

module recovery_fsm (
    input  logic                 clock,
    input  logic                 reset,
    input  branch_pkg::restore_t restore_candidate,
    input  logic                 timer_done,
    output logic                 timer_start,
    output branch_pkg::restore_t restore,
    output logic                 recovering
);

    branch_pkg::recovery_state_t state;
    branch_pkg::recovery_state_t state_next;

    // A candidate only starts a repair from idle
    assign timer_start = (state == branch_pkg::state_idle) && restore_candidate.valid;

    always_comb begin
        state_next = state;
        case (state)
            branch_pkg::state_idle: begin
                if (timer_start) begin
                    state_next = branch_pkg::state_repair;
                end
            end
            branch_pkg::state_repair: begin
                if (timer_done) begin
                    state_next = branch_pkg::state_idle;
                end
            end
            default: begin
                state_next = branch_pkg::state_idle;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= branch_pkg::state_idle;
        end else begin
            state <= state_next;
        end
    end

    // Restore packet is valid for the single cycle after acceptance
    always_ff @(posedge clock) begin
        if (reset) begin
            restore.valid <= 1'b0;
        end else if (timer_start) begin
            restore <= restore_candidate;
        end else begin
            restore.valid <= 1'b0;
        end
    end

    // Repair state spans the restore cycle and the stall that follows
    assign recovering = (state == branch_pkg::state_repair);

endmodule

//--- hdl/repair_timer.sv
`timescale 1ns/1ps

module repair_timer (
    input  logic clock,
    input  logic reset,
    input  logic start,
    output logic done
);

    branch_pkg::timer_count_t count;
    logic                     active;

    always_ff @(posedge clock) begin
        if (reset) begin
            count  <= '0;
            active <= 1'b0;
        end else if (start) begin
            count  <= branch_pkg::timer_count_t'(branch_pkg::repair_cycles - 1);
            active <= 1'b1;
        end else if (active) begin
            if (count == '0) begin
                active <= 1'b0;
            end else begin
                count <= count - 1'b1;
            end
        end
    end

    // High in the last repair cycle only
    assign done = active && (count == '0);

endmodule

//--- hdl/branch_recovery_top.sv
`timescale 1ns/1ps

module branch_recovery_top (
    input  logic                    clock,
    input  logic                    reset,

    // Dispatch side
    input  logic                    ckpt_valid,
    input  branch_pkg::ckpt_req_t   ckpt_req,
    output logic                    ckpt_ready,
    output branch_pkg::tag_t        alloc_tag,
    output branch_pkg::b_mask_t     branch_mask,

    // Branch resolution
    input  logic                    resolve_valid,
    input  branch_pkg::resolve_t    resolve,
    output logic                    resolve_ready,

    // Retirement frees
    input  branch_pkg::free_list_t  free_list_in,

    // Recovery and predictor outputs
    output branch_pkg::restore_t    restore,
    output logic                    recovering,
    output branch_pkg::btb_update_t btb_update
);

    branch_pkg::restore_t restore_candidate;
    logic                 timer_start;
    logic                 timer_done;

    checkpoint_stack checkpoint_stack_inst (
        .clock             (clock),
        .reset             (reset),
        .ckpt_valid        (ckpt_valid),
        .ckpt_req          (ckpt_req),
        .ckpt_ready        (ckpt_ready),
        .alloc_tag         (alloc_tag),
        .branch_mask       (branch_mask),
        .resolve_valid     (resolve_valid),
        .resolve           (resolve),
        .resolve_ready     (resolve_ready),
        .free_list_in      (free_list_in),
        .recovering        (recovering),
        .restore_candidate (restore_candidate),
        .btb_update        (btb_update)
    );

    // Registers the restore and holds the stall
    recovery_fsm recovery_fsm_inst (
        .clock             (clock),
        .reset             (reset),
        .restore_candidate (restore_candidate),
        .timer_done        (timer_done),
        .timer_start       (timer_start),
        .restore           (restore),
        .recovering        (recovering)
    );

    repair_timer repair_timer_inst (
        .clock (clock),
        .reset (reset),
        .start (timer_start),
        .done  (timer_done)
    );

endmodule

//--- include/branch_recovery_model.svh
`ifndef BRANCH_RECOVERY_MODEL_SVH
`define BRANCH_RECOVERY_MODEL_SVH

// Shadow copy of the checkpoint entries
branch_pkg::checkpoint_t model_ckpt [branch_pkg::num_tags];

function automatic void model_reset();
    for (int i = 0; i < branch_pkg::num_tags; i++) begin
        model_ckpt[i] = '0;
    end
endfunction

function automatic branch_pkg::b_mask_t model_live_mask();
    branch_pkg::b_mask_t live;
    live = '0;
    for (int i = 0; i < branch_pkg::num_tags; i++) begin
        live[i] = model_ckpt[i].valid;
    end
    return live;
endfunction

// Returns -1 when every tag is in use
function automatic int lowest_free_tag(input branch_pkg::b_mask_t live);
    for (int i = 0; i < branch_pkg::num_tags; i++) begin
        if (!live[i]) begin
            return i;
        end
    end
    return -1;
endfunction

function automatic branch_pkg::b_mask_t squash_set(input int tag);
    branch_pkg::b_mask_t set;
    set      = '0;
    set[tag] = 1'b1;
    for (int i = 0; i < branch_pkg::num_tags; i++) begin
        if (model_ckpt[i].valid && model_ckpt[i].depend_mask[tag]) begin
            set[i] = 1'b1;
        end
    end
    return set;
endfunction

function automatic branch_pkg::free_list_t merged_free_list(
    input branch_pkg::free_list_t saved,
    input branch_pkg::free_list_t retired
);
    return saved | retired;
endfunction

function automatic logic model_mispredict(
    input branch_pkg::checkpoint_t ckpt,
    input branch_pkg::resolve_t    res
);
    if (ckpt.req.is_jump) begin
        return res.target_pc != ckpt.req.predicted_target;
    end
    return res.mispredict;
endfunction

// PC rule plus the saved state, retired frees of the resolving cycle included
function automatic branch_pkg::restore_t expected_restore(
    input branch_pkg::checkpoint_t ckpt,
    input branch_pkg::resolve_t    res,
    input branch_pkg::free_list_t  retired
);
    branch_pkg::restore_t exp;
    exp.valid     = 1'b1;
    exp.pc        = (ckpt.req.is_jump || res.taken) ? res.target_pc : ckpt.req.fallthrough_pc;
    exp.rob_tail  = ckpt.req.rob_tail;
    exp.map_table = ckpt.req.map_table;
    exp.free_list = merged_free_list(ckpt.req.free_list, retired);
    return exp;
endfunction

`endif

//--- verif/branch_recovery_tb.sv
`timescale 1ns/1ps

module branch_recovery_tb;

    logic                    clock;
    logic                    reset;
    logic                    ckpt_valid;
    branch_pkg::ckpt_req_t   ckpt_req;
    logic                    ckpt_ready;
    branch_pkg::tag_t        alloc_tag;
    branch_pkg::b_mask_t     branch_mask;
    logic                    resolve_valid;
    branch_pkg::resolve_t    resolve;
    logic                    resolve_ready;
    branch_pkg::free_list_t  free_list_in;
    branch_pkg::restore_t    restore;
    logic                    recovering;
    branch_pkg::btb_update_t btb_update;

    // Expected packets and the edge count at which each one is sampled
    branch_pkg::restore_t    exp_restore_q[$];
    int                      exp_restore_at_q[$];
    branch_pkg::btb_update_t exp_btb_q[$];
    int                      exp_btb_at_q[$];

    int    edge_count;
    int    rec_first;
    int    rec_last;
    int    test_errors;
    int    tests_passed;
    int    tests_failed;
    string test_name;
    logic  ckpt_taken;
    logic  resolve_taken;

    `include "branch_recovery_model.svh"

    branch_recovery_top branch_recovery_top_inst (.*);

    always #5 clock = ~clock;

    task automatic report_mismatch(input string what, input logic [127:0] expected,
                                   input logic [127:0] actual);
        $display("ERROR %s %s expected %h actual %h", test_name, what, expected, actual);
        test_errors++;
    endtask

    task automatic report_failure(input string msg);
        $display("%s: %s", test_name, msg);
        test_errors++;
    endtask

    // Cycle n is the one that begins at edge n
    function automatic logic in_repair(input int n);
        return (n >= rec_first) && (n <= rec_last);
    endfunction

    function automatic branch_pkg::ckpt_req_t random_req(input logic jump);
        branch_pkg::ckpt_req_t req;
        req.branch_pc        = $urandom & 32'hffff_fffc;
        req.fallthrough_pc   = req.branch_pc + 32'd4;
        req.predicted_target = $urandom & 32'hffff_fffc;
        req.is_jump          = jump;
        req.rob_tail         = branch_pkg::rob_idx_t'($urandom);
        req.map_table        = $urandom;
        req.free_list        = branch_pkg::free_list_t'($urandom);
        return req;
    endfunction

    function automatic branch_pkg::resolve_t make_resolve(input int tag, input logic mispredict,
                                                          input logic taken,
                                                          input branch_pkg::addr_t target);
        branch_pkg::resolve_t res;
        res.tag        = branch_pkg::tag_t'(tag);
        res.mispredict = mispredict;
        res.taken      = taken;
        res.target_pc  = target;
        return res;
    endfunction

    // Compare registered outputs with the values they held during the cycle just ended
    always @(posedge clock) begin
        edge_count = edge_count + 1;
        if (!reset) begin
            if (recovering !== in_repair(edge_count - 1)) begin
                report_mismatch("recovering", in_repair(edge_count - 1), recovering);
            end
            if (exp_restore_at_q.size() > 0 && exp_restore_at_q[0] == edge_count) begin
                if (restore !== exp_restore_q[0]) begin
                    report_mismatch("restore", exp_restore_q[0], restore);
                end
                exp_restore_q.delete(0);
                exp_restore_at_q.delete(0);
            end else if (restore.valid !== 1'b0) begin
                report_failure("restore packet appeared with no mispredict pending");
            end
            if (exp_btb_at_q.size() > 0 && exp_btb_at_q[0] == edge_count) begin
                if (btb_update !== exp_btb_q[0]) begin
                    report_mismatch("btb_update", exp_btb_q[0], btb_update);
                end
                exp_btb_q.delete(0);
                exp_btb_at_q.delete(0);
            end else if (btb_update.valid !== 1'b0) begin
                report_failure("predictor update appeared with no live resolve pending");
            end
        end
    end

    // Drives one cycle of stimulus
    // The model follows what the DUT should accept at the next edge
    task automatic step(input logic cv, input branch_pkg::ckpt_req_t req, input logic rv,
                        input branch_pkg::resolve_t res, input branch_pkg::free_list_t retired);
        int                      n;
        int                      tag;
        logic                    recov;
        logic                    mp;
        branch_pkg::b_mask_t     kill;
        branch_pkg::checkpoint_t hit;
        branch_pkg::btb_update_t btb;
        @(negedge clock);
        ckpt_valid    = cv;
        ckpt_req      = req;
        resolve_valid = rv;
        resolve       = res;
        free_list_in  = retired;
        n     = edge_count;
        recov = in_repair(n);
        tag   = lowest_free_tag(model_live_mask());
        if (branch_mask !== model_live_mask()) begin
            report_mismatch("branch_mask", model_live_mask(), branch_mask);
        end
        if (ckpt_ready !== (tag >= 0 && !recov)) begin
            report_mismatch("ckpt_ready", (tag >= 0 && !recov), ckpt_ready);
        end
        if (resolve_ready !== !recov) begin
            report_mismatch("resolve_ready", !recov, resolve_ready);
        end
        if (tag >= 0 && alloc_tag !== branch_pkg::tag_t'(tag)) begin
            report_mismatch("alloc_tag", tag, alloc_tag);
        end
        ckpt_taken    = cv && tag >= 0 && !recov;
        resolve_taken = rv && !recov;
        mp = 1'b0;
        if (resolve_taken && model_ckpt[res.tag].valid) begin
            hit = model_ckpt[res.tag];
            mp  = model_mispredict(hit, res);
            btb.valid     = 1'b1;
            btb.is_branch = !hit.req.is_jump;
            btb.taken     = hit.req.is_jump || res.taken;
            btb.branch_pc = hit.req.branch_pc;
            btb.target_pc = res.target_pc;
            exp_btb_q.push_back(btb);
            exp_btb_at_q.push_back(n + 2);
            if (mp) begin
                exp_restore_q.push_back(expected_restore(hit, res, retired));
                exp_restore_at_q.push_back(n + 2);
                rec_first = n + 1;
                rec_last  = n + branch_pkg::repair_cycles;
                kill = squash_set(res.tag);
                for (int i = 0; i < branch_pkg::num_tags; i++) begin
                    if (kill[i]) begin
                        model_ckpt[i].valid = 1'b0;
                    end
                end
            end else begin
                model_ckpt[res.tag].valid = 1'b0;
                for (int i = 0; i < branch_pkg::num_tags; i++) begin
                    model_ckpt[i].depend_mask[res.tag] = 1'b0;
                end
            end
        end
        for (int i = 0; i < branch_pkg::num_tags; i++) begin
            if (model_ckpt[i].valid) begin
                model_ckpt[i].req.free_list = merged_free_list(model_ckpt[i].req.free_list,
                                                               retired);
            end
        end
        // Wrong-path checkpoint next to a mispredict is dropped
        if (ckpt_taken && !mp) begin
            model_ckpt[tag].valid       = 1'b1;
            model_ckpt[tag].depend_mask = model_live_mask();
            model_ckpt[tag].req         = req;
        end
    endtask

    task automatic idle(input int cycles, input branch_pkg::free_list_t retired);
        repeat (cycles) step(1'b0, '0, 1'b0, '0, retired);
    endtask

    task automatic dispatch(input branch_pkg::ckpt_req_t req);
        step(1'b1, req, 1'b0, '0, '0);
        if (!ckpt_taken) begin
            report_failure("checkpoint could not be dispatched");
        end
    endtask

    task automatic resolve_tag(input int tag, input logic mispredict, input logic taken,
                               input branch_pkg::addr_t target,
                               input branch_pkg::free_list_t retired);
        step(1'b0, '0, 1'b1, make_resolve(tag, mispredict, taken, target), retired);
    endtask

    task automatic clear_live_tags();
        for (int t = 0; t < branch_pkg::num_tags; t++) begin
            if (model_ckpt[t].valid) begin
                resolve_tag(t, 1'b0, $urandom % 2 == 1, model_ckpt[t].req.predicted_target, '0);
            end
        end
    endtask

    // Wait for pending outputs to be checked and the repair period to end
    task automatic settle();
        int waited;
        waited = 0;
        while (exp_restore_q.size() + exp_btb_q.size() > 0 || in_repair(edge_count)) begin
            if (waited == 20) begin
                report_failure("timed out waiting for expected outputs and the end of repair");
                exp_restore_q.delete();
                exp_restore_at_q.delete();
                exp_btb_q.delete();
                exp_btb_at_q.delete();
                break;
            end
            idle(1, '0);
            waited++;
        end
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic finish_test();
        settle();
        clear_live_tags();
        settle();
        if (test_errors == 0) begin
            $display("Test %s passed", test_name);
            tests_passed++;
        end else begin
            $display("Test %s failed with %0d errors", test_name, test_errors);
            tests_failed++;
        end
    endtask

    initial begin
        branch_pkg::ckpt_req_t req;
        branch_pkg::resolve_t  res;
        int                    waited;
        void'($urandom(43));
        clock         = 1'b0;
        reset         = 1'b1;
        ckpt_valid    = 1'b0;
        ckpt_req      = '0;
        resolve_valid = 1'b0;
        resolve       = '0;
        free_list_in  = '0;
        edge_count    = 0;
        rec_first     = 1;
        rec_last      = 0;
        tests_passed  = 0;
        tests_failed  = 0;
        start_test("reset");
        model_reset();
        repeat (16) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;

        start_test("allocation");
        for (int i = 0; i < branch_pkg::num_tags; i++) begin
            dispatch(random_req(1'b0));
        end
        idle(1, '0);
        if (branch_mask !== 4'b1111) begin
            report_mismatch("branch_mask_full", 4'b1111, branch_mask);
        end
        // Held request must be refused while every tag is in use
        step(1'b1, random_req(1'b0), 1'b0, '0, '0);
        finish_test();

        start_test("correct_resolve");
        for (int i = 0; i < branch_pkg::num_tags; i++) begin
            dispatch(random_req(1'b0));
        end
        resolve_tag(1, 1'b0, 1'b1, model_ckpt[1].req.predicted_target, '0);
        resolve_tag(3, 1'b0, 1'b0, model_ckpt[3].req.predicted_target, '0);
        resolve_tag(1, 1'b1, 1'b1, $urandom, '0);
        idle(1, '0);
        if (branch_mask !== 4'b0101) begin
            report_mismatch("branch_mask_after_resolve", 4'b0101, branch_mask);
        end
        finish_test();

        start_test("branch_mispredict");
        for (int i = 0; i < branch_pkg::num_tags; i++) begin
            dispatch(random_req(1'b0));
        end
        resolve_tag(1, 1'b1, $urandom % 2 == 1, $urandom & 32'hffff_fffc, '0);
        idle(1, '0);
        if (branch_mask !== 4'b0001) begin
            report_mismatch("branch_mask_after_squash", 4'b0001, branch_mask);
        end
        finish_test();

        start_test("jump_target");
        req = random_req(1'b1);
        dispatch(req);
        resolve_tag(0, 1'b1, 1'b1, req.predicted_target, '0);
        req = random_req(1'b1);
        dispatch(req);
        resolve_tag(0, 1'b0, 1'b0, req.predicted_target ^ 32'h0000_0040, '0);
        finish_test();

        start_test("repair_stall");
        dispatch(random_req(1'b0));
        dispatch(random_req(1'b0));
        resolve_tag(1, 1'b1, 1'b0, $urandom & 32'hffff_fffc, '0);
        req = random_req(1'b0);
        res = make_resolve(0, 1'b0, 1'b1, model_ckpt[0].req.predicted_target);
        waited = 0;
        step(1'b1, req, 1'b1, res, '0);
        while ((ckpt_ready !== 1'b1 || resolve_ready !== 1'b1) && waited < 10) begin
            waited++;
            step(1'b1, req, 1'b1, res, '0);
        end
        if (ckpt_ready !== 1'b1 || resolve_ready !== 1'b1) begin
            report_failure("held dispatch and resolve were not taken after the repair period");
        end else if (waited != branch_pkg::repair_cycles) begin
            report_mismatch("stall_cycles", branch_pkg::repair_cycles, waited);
        end
        finish_test();

        start_test("free_list_merge");
        dispatch(random_req(1'b0));
        dispatch(random_req(1'b0));
        idle(3, branch_pkg::free_list_t'($urandom));
        idle(1, branch_pkg::free_list_t'($urandom));
        resolve_tag(0, 1'b1, $urandom % 2 == 1, $urandom & 32'hffff_fffc,
                    branch_pkg::free_list_t'($urandom));
        finish_test();

        $display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- branch_recovery_top.f
+incdir+include
hdl/branch_pkg.sv
hdl/checkpoint_stack.sv
hdl/recovery_fsm.sv
hdl/repair_timer.sv
hdl/branch_recovery_top.sv
verif/branch_recovery_tb.sv
